/* logic/cosPkg.sv */
// Shared clock, baud, reset, register-address and command constants
`default_nettype none

package cosPkg;

  // Clocking and serial rate
  localparam int ClockTopHz = 50_000_000;
  localparam int UartBaud = 5_000_000;
  localparam int BitCycles = ClockTopHz / UartBaud;

  // Stretched reset covers at least one bit time
  localparam int ResetCycles = BitCycles + 50;

  // Wishbone geometry
  localparam int RegAdrWidth = 2;
  localparam int RegDataWidth = 32;

  // Register map
  localparam logic [RegAdrWidth-1:0] AdrChipId = 2'd0;
  localparam logic [RegAdrWidth-1:0] AdrUptime = 2'd1;
  localparam logic [RegAdrWidth-1:0] AdrScratch = 2'd2;
  localparam logic [RegAdrWidth-1:0] AdrControl = 2'd3;

  localparam logic [RegDataWidth-1:0] CosChipId = 32'h0C05_0001;

  // Command bytes
  localparam logic [7:0] CmdRead = "r";
  localparam logic [7:0] CmdWrite = "w";
  localparam logic [7:0] CmdReset = "!";

  // Response bytes
  localparam logic [7:0] RespOk = "k";
  localparam logic [7:0] RespBad = "?";

  localparam int LedCount = 3;

endpackage

`default_nettype wire

/* logic/cosReset.sv */
// Reset combiner with release synchronizer and stretch counter
`timescale 1ns/1ps
`default_nettype none

module cosReset
  import cosPkg::*;
(
  input  logic clockTop,
  input  logic arstN,
  input  logic softReset,
  output logic resetN
);

  typedef logic [$clog2(ResetCycles + 1)-1:0] holdT;

  logic [1:0] syncQ;
  holdT       holdCount;

  // Pin reset asserts at once, release goes through two flops
  always_ff @(posedge clockTop or negedge arstN) begin
    if (!arstN) begin
      syncQ <= 2'b00;
      holdCount <= holdT'(ResetCycles);
      resetN <= 1'b0;
    end else begin
      syncQ <= {syncQ[0], 1'b1};
      if (softReset || !syncQ[1]) begin
        // Either source restarts the stretch
        holdCount <= holdT'(ResetCycles);
        resetN <= 1'b0;
      end else if (holdCount != '0) begin
        holdCount <= holdCount - 1'b1;
        resetN <= 1'b0;
      end else begin
        resetN <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/uartRx.sv */
// Serial receiver, 8N1, one byte per valid pulse
`timescale 1ns/1ps
`default_nettype none

module uartRx
  import cosPkg::*;
(
  input  logic       clockTop,
  input  logic       arstN,
  input  logic       rxLine,
  output logic [7:0] rxData,
  output logic       rxValid
);

  typedef logic [$clog2(BitCycles)-1:0] timerT;
  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rxStateT;

  rxStateT    state;
  logic [1:0] rxSync;
  timerT      bitTimer;
  logic [2:0] bitIndex;

  always_ff @(posedge clockTop or negedge arstN) begin
    if (!arstN) begin
      rxSync <= 2'b11;
      state <= RxIdle;
      bitTimer <= '0;
      bitIndex <= '0;
      rxValid <= 1'b0;
    end else begin
      rxSync <= {rxSync[0], rxLine};
      rxValid <= 1'b0;
      if (state != RxIdle && bitTimer != '0) begin
        bitTimer <= bitTimer - 1'b1;
      end else begin
        case (state)
          RxIdle: begin
            // Start edge, wait half a bit to reach its middle
            if (!rxSync[1]) begin
              state <= RxStart;
              bitTimer <= timerT'(BitCycles / 2 - 1);
            end
          end
          RxStart: begin
            bitTimer <= timerT'(BitCycles - 1);
            bitIndex <= '0;
            // A glitch that is gone by mid-bit is not a start bit
            state <= rxSync[1] ? RxIdle : RxData;
          end
          RxData: begin
            bitTimer <= timerT'(BitCycles - 1);
            bitIndex <= bitIndex + 1'b1;
            if (bitIndex == 3'd7) begin
              state <= RxStop;
            end
          end
          default: begin
            // Bad stop bit drops the byte
            rxValid <= rxSync[1];
            state <= RxIdle;
          end
        endcase
      end
    end
  end

  // LSB first into the top of the byte
  always_ff @(posedge clockTop) begin
    if (state == RxData && bitTimer == '0) begin
      rxData <= {rxSync[1], rxData[7:1]};
    end
  end

endmodule

`default_nettype wire

/* logic/uartTx.sv */
// Serial transmitter, 8N1, with busy flag
`timescale 1ns/1ps
`default_nettype none

module uartTx
  import cosPkg::*;
(
  input  logic       clockTop,
  input  logic       arstN,
  input  logic [7:0] txData,
  input  logic       txStart,
  output logic       txLine,
  output logic       txBusy
);

  typedef logic [$clog2(BitCycles)-1:0] timerT;

  logic [9:0] frame;
  timerT      bitTimer;
  logic [3:0] bitsLeft;

  always_ff @(posedge clockTop or negedge arstN) begin
    if (!arstN) begin
      frame <= '1;
      bitTimer <= '0;
      bitsLeft <= '0;
      txBusy <= 1'b0;
    end else if (!txBusy) begin
      if (txStart) begin
        // Stop bit, data LSB first, start bit
        frame <= {1'b1, txData, 1'b0};
        bitTimer <= timerT'(BitCycles - 1);
        bitsLeft <= 4'd9;
        txBusy <= 1'b1;
      end
    end else if (bitTimer != '0) begin
      bitTimer <= bitTimer - 1'b1;
    end else if (bitsLeft == '0) begin
      // End of stop bit
      txBusy <= 1'b0;
    end else begin
      frame <= {1'b1, frame[9:1]};
      bitTimer <= timerT'(BitCycles - 1);
      bitsLeft <= bitsLeft - 1'b1;
    end
  end

  // Frame idles at all ones, so the line idles high
  assign txLine = frame[0];

endmodule

`default_nettype wire

/* logic/uartControl.sv */
// Serial command parser acting as Wishbone master, with reply sequencer
`timescale 1ns/1ps
`default_nettype none

module uartControl
  import cosPkg::*;
(
  input  logic                    clockTop,
  input  logic                    arstN,
  input  logic [7:0]              rxData,
  input  logic                    rxValid,
  output logic [7:0]              txData,
  output logic                    txStart,
  input  logic                    txBusy,
  output logic                    softReset,
  output logic                    wbCyc,
  output logic                    wbStb,
  output logic                    wbWe,
  output logic [RegAdrWidth-1:0]  wbAdr,
  output logic [RegDataWidth-1:0] wbDatW,
  input  logic [RegDataWidth-1:0] wbDatR,
  input  logic                    wbAck
);

  typedef enum logic [2:0] {CtlIdle, CtlAddr, CtlData, CtlBus, CtlReply} ctlStateT;

  ctlStateT                state;
  logic [1:0]              byteCount;
  logic [1:0]              bytesLeft;
  logic [RegDataWidth-1:0] replyReg;
  logic                    sendByte;

  // Next reply byte goes out once the transmitter is free
  assign sendByte = (state == CtlReply) && !txBusy && !txStart;

  always_ff @(posedge clockTop or negedge arstN) begin
    if (!arstN) begin
      state <= CtlIdle;
      byteCount <= '0;
      bytesLeft <= '0;
      txStart <= 1'b0;
      softReset <= 1'b0;
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe <= 1'b0;
    end else begin
      txStart <= 1'b0;
      softReset <= 1'b0;
      case (state)
        CtlIdle: begin
          if (rxValid) begin
            if (rxData == CmdRead || rxData == CmdWrite) begin
              wbWe <= (rxData == CmdWrite);
              state <= CtlAddr;
            end else if (rxData == CmdReset) begin
              softReset <= 1'b1;
            end else begin
              // Unknown command, single RespBad byte
              bytesLeft <= '0;
              state <= CtlReply;
            end
          end
        end
        CtlAddr: begin
          if (rxValid) begin
            byteCount <= 2'd3;
            if (wbWe) begin
              state <= CtlData;
            end else begin
              wbCyc <= 1'b1;
              wbStb <= 1'b1;
              state <= CtlBus;
            end
          end
        end
        CtlData: begin
          if (rxValid) begin
            byteCount <= byteCount - 1'b1;
            if (byteCount == '0) begin
              wbCyc <= 1'b1;
              wbStb <= 1'b1;
              state <= CtlBus;
            end
          end
        end
        CtlBus: begin
          if (wbAck) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            // Read returns four bytes, write only RespOk
            bytesLeft <= wbWe ? 2'd0 : 2'd3;
            state <= CtlReply;
          end
        end
        default: begin
          if (sendByte) begin
            txStart <= 1'b1;
            bytesLeft <= bytesLeft - 1'b1;
            if (bytesLeft == '0) begin
              state <= CtlIdle;
            end
          end
        end
      endcase
    end
  end

  // Address, write data and reply bytes
  always_ff @(posedge clockTop) begin
    if (state == CtlIdle && rxValid) begin
      replyReg <= {RespBad, {(RegDataWidth - 8){1'b0}}};
    end
    if (state == CtlAddr && rxValid) begin
      wbAdr <= rxData[RegAdrWidth-1:0];
    end
    if (state == CtlData && rxValid) begin
      wbDatW <= {wbDatW[RegDataWidth-9:0], rxData};
    end
    if (state == CtlBus && wbAck) begin
      replyReg <= wbWe ? {RespOk, {(RegDataWidth - 8){1'b0}}} : wbDatR;
    end
    if (sendByte) begin
      txData <= replyReg[RegDataWidth-1 -: 8];
      replyReg <= replyReg << 8;
    end
  end

endmodule

`default_nettype wire

/* logic/statusRegs.sv */
// Wishbone register block with chip id, uptime, scratch, control and LED drive
`timescale 1ns/1ps
`default_nettype none

module statusRegs
  import cosPkg::*;
(
  input  logic                    clockTop,
  input  logic                    arstN,
  input  logic                    wbCyc,
  input  logic                    wbStb,
  input  logic                    wbWe,
  input  logic [RegAdrWidth-1:0]  wbAdr,
  input  logic [RegDataWidth-1:0] wbDatW,
  output logic [RegDataWidth-1:0] wbDatR,
  output logic                    wbAck,
  output logic [LedCount-1:0]     ledOut
);

  logic [RegDataWidth-1:0] uptime;
  logic [RegDataWidth-1:0] scratch;
  logic [RegDataWidth-1:0] control;
  logic                    access;

  // First cycle of a request, ack follows on the next one
  assign access = wbCyc && wbStb && !wbAck;

  always_ff @(posedge clockTop or negedge arstN) begin
    if (!arstN) begin
      uptime <= '0;
      scratch <= '0;
      control <= '0;
      wbAck <= 1'b0;
      ledOut <= '0;
    end else begin
      uptime <= uptime + 1'b1;
      wbAck <= access;
      // Chip id and uptime are read only
      if (access && wbWe) begin
        case (wbAdr)
          AdrScratch: scratch <= wbDatW;
          AdrControl: control <= wbDatW;
          default: ;
        endcase
      end
      // Blink bit forces every LED on
      ledOut <= uptime[24 -: LedCount] | {LedCount{control[0]}};
    end
  end

  // Read data lines up with the ack cycle
  always_ff @(posedge clockTop) begin
    if (access) begin
      case (wbAdr)
        AdrChipId: wbDatR <= CosChipId;
        AdrUptime: wbDatR <= uptime;
        AdrScratch: wbDatR <= scratch;
        default: wbDatR <= control;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/cosTop.sv */
// Chip top level with reset, serial port, command parser and register block
`timescale 1ns/1ps
`default_nettype none

module cosTop
  import cosPkg::*;
(
  input  logic                clockTop,
  input  logic                arstN,
  input  logic                uartRx,
  output logic                uartTx,
  output logic [LedCount-1:0] ledOut
);

  logic                    resetN;
  logic                    softReset;
  logic [7:0]              rxData;
  logic                    rxValid;
  logic [7:0]              txData;
  logic                    txStart;
  logic                    txBusy;
  logic                    wbCyc;
  logic                    wbStb;
  logic                    wbWe;
  logic [RegAdrWidth-1:0]  wbAdr;
  logic [RegDataWidth-1:0] wbDatW;
  logic [RegDataWidth-1:0] wbDatR;
  logic                    wbAck;

  // Pin reset and soft reset merge here, everything else runs on resetN
  cosReset uReset (
    .clockTop(clockTop), .arstN(arstN), .softReset(softReset), .resetN(resetN)
  );

  uartRx uRx (
    .clockTop(clockTop), .arstN(resetN), .rxLine(uartRx),
    .rxData(rxData), .rxValid(rxValid)
  );

  uartTx uTx (
    .clockTop(clockTop), .arstN(resetN), .txData(txData), .txStart(txStart),
    .txLine(uartTx), .txBusy(txBusy)
  );

  uartControl uControl (
    .clockTop(clockTop), .arstN(resetN),
    .rxData(rxData), .rxValid(rxValid),
    .txData(txData), .txStart(txStart), .txBusy(txBusy),
    .softReset(softReset),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
  );

  // Wishbone slave side
  statusRegs uRegs (
    .clockTop(clockTop), .arstN(resetN),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
    .ledOut(ledOut)
  );

endmodule

`default_nettype wire

/* bench/cosClockGen.sv */
// Testbench clock generator and power-on reset
`timescale 1ns/1ps
`default_nettype none

module cosClockGen (
  output logic clockTop,
  output logic arstN
);

  // 20 ns period
  initial begin
    clockTop = 1'b0;
    forever #10 clockTop = ~clockTop;
  end

  // Pin reset held low for two clock cycles
  initial begin
    arstN = 1'b0;
    repeat (2) @(posedge clockTop);
    arstN <= 1'b1;
  end

endmodule

`default_nettype wire

/* bench/cosTopTb.sv */
// Testbench top with serial driver, reply monitor, LFSR data, checks, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module cosTopTb
  import cosPkg::*;
();

  // Bytes sent and received over all tests rounded up
  localparam int CommandBytes = 130;
  localparam int WatchdogNs = (2 * CommandBytes * 10 * BitCycles + 2 * ResetCycles) * 20;

  logic                clockTop;
  logic                arstN;
  logic                serialIn = 1'b1;
  logic                serialOut;
  logic [LedCount-1:0] ledOut;
  logic [7:0]          replyQ[$];
  logic [31:0]         lfsrState = 32'd2;
  int                  errorCount = 0;
  int                  errorsAtStart = 0;
  int                  passCount = 0;
  int                  failCount = 0;

  cosClockGen clockGen (.clockTop(clockTop), .arstN(arstN));

  cosTop DUT (
    .clockTop(clockTop), .arstN(arstN), .uartRx(serialIn), .uartTx(serialOut),
    .ledOut(ledOut)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic lfsrBit();
    lfsrBit = lfsrState[0];
    lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got === expected) else begin
      $display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, expected);
      errorCount++;
    end
  endtask

  // 8N1 frame, one bit every BitCycles clocks
  task automatic sendByte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clockTop);
      serialIn <= frame[i];
      repeat (BitCycles - 1) @(posedge clockTop);
    end
  endtask

  task automatic runCommand(input logic [7:0] cmd, input logic [1:0] adr,
                            input logic [31:0] data, input int replyCount);
    replyQ.delete();
    sendByte(cmd);
    if (cmd == CmdRead || cmd == CmdWrite) sendByte({6'b0, adr});
    // Write data goes most significant byte first
    for (int i = 3; i >= 0 && cmd == CmdWrite; i--) sendByte(data[8*i +: 8]);
    while (replyQ.size() < replyCount) @(posedge clockTop);
    if (cmd == CmdWrite) checkValue("write reply", 32'(replyQ[0]), 32'(RespOk));
  endtask

  task automatic readRegister(input logic [1:0] adr, output logic [31:0] value);
    runCommand(CmdRead, adr, '0, 4);
    value = {replyQ[0], replyQ[1], replyQ[2], replyQ[3]};
  endtask

  task automatic expectRead(input logic [1:0] adr, input logic [31:0] expected,
                            input string what);
    logic [31:0] value;
    readRegister(adr, value);
    checkValue(what, value, expected);
  endtask

  task automatic expectLeds(input logic [LedCount-1:0] expected, input int cycles);
    repeat (cycles) begin
      @(negedge clockTop);
      checkValue("leds", 32'(ledOut), 32'(expected));
    end
  endtask

  task automatic endTest(input int number, input string name);
    if (errorCount == errorsAtStart) passCount++;
    else failCount++;
    $display("Test %0d %s: %0d errors", number, name, errorCount - errorsAtStart);
    errorsAtStart = errorCount;
  endtask

  // Mid-bit sampling, timed from the falling start edge
  always begin : replyMonitor
    logic [7:0] received;
    @(negedge clockTop);
    if (arstN && serialOut === 1'b0) begin
      repeat (BitCycles / 2) @(negedge clockTop);
      for (int i = 0; i < 8; i++) begin
        repeat (BitCycles) @(negedge clockTop);
        received[i] = serialOut;
      end
      repeat (BitCycles) @(negedge clockTop);
      checkValue("reply stop bit", 32'(serialOut), 32'd1);
      replyQ.push_back(received);
    end
  end

  // Twice the bit time of all traffic plus the reset stretch
  initial begin : watchdog
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : testSequence
    logic [31:0] data;
    logic [31:0] uptimeA;
    logic [31:0] uptimeB;
    @(posedge arstN);
    repeat (ResetCycles + 10) @(posedge clockTop);
    expectRead(AdrChipId, CosChipId, "chip id");
    expectRead(AdrScratch, '0, "scratch after reset");
    expectLeds('0, 1);
    endTest(1, "reset values");

    repeat (3) begin
      repeat (32) data = {data[30:0], lfsrBit()};
      runCommand(CmdWrite, AdrScratch, data, 1);
      expectRead(AdrScratch, data, "scratch read back");
    end
    endTest(2, "scratch write and read back");

    readRegister(AdrUptime, uptimeA);
    readRegister(AdrUptime, uptimeB);
    checkValue("uptime increase flag", 32'(uptimeB > uptimeA), 32'd1);
    // Uptime is read only, the write must not clear it
    runCommand(CmdWrite, AdrUptime, 32'd0, 1);
    readRegister(AdrUptime, uptimeA);
    checkValue("uptime increase flag after write", 32'(uptimeA > uptimeB), 32'd1);
    endTest(3, "uptime counter");

    runCommand(8'h5A, '0, '0, 1);
    checkValue("unknown command reply", 32'(replyQ[0]), 32'(RespBad));
    expectRead(AdrChipId, CosChipId, "chip id after unknown command");
    endTest(4, "unknown command");

    runCommand(CmdWrite, AdrControl, 32'd1, 1);
    expectLeds('1, 5 * BitCycles);
    expectRead(AdrControl, 32'd1, "control read back");
    endTest(5, "led blink bit");

    readRegister(AdrUptime, uptimeA);
    runCommand(CmdReset, '0, '0, 0);
    // No reply and an idle line through the stretched reset
    repeat (ResetCycles + 40) begin
      @(negedge clockTop);
      checkValue("uart line during reset", 32'(serialOut), 32'd1);
    end
    checkValue("reply bytes to reset command", 32'(replyQ.size()), '0);
    expectRead(AdrScratch, '0, "scratch after soft reset");
    expectRead(AdrControl, '0, "control after soft reset");
    expectLeds('0, 1);
    readRegister(AdrUptime, uptimeB);
    checkValue("uptime restart flag", 32'(uptimeB < uptimeA), 32'd1);
    endTest(6, "soft reset");

    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cosTop.f */
logic/cosPkg.sv
logic/cosReset.sv
logic/uartRx.sv
logic/uartTx.sv
logic/uartControl.sv
logic/statusRegs.sv
logic/cosTop.sv
bench/cosClockGen.sv
bench/cosTopTb.sv

/* runSim.sh */
#!/bin/sh
# Compile and run the cosTop testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cosTopTb -f cosTop.f -o cosTopSim
output=$(./obj_dir/cosTopSim)
echo "$output"
echo "$output" | grep -qF '*** TEST PASSED ***'
